// ==== verilog/lsu_pkg.sv ====
// Shared widths and types of the load/store unit.
// The scratchpad window is 4 KiB, addressed by word index and byte offset.
// Only 32-bit data is supported; there are no doubleword operations.

package lsu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned TransIdWidth = 3;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned IdxWidth     = 10;
  localparam int unsigned TagWidth     = 20;

  // --------------------------------------------------
  // Operations and exception causes
  // --------------------------------------------------
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  // RISC-V mcause codes for data accesses
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } ex_cause_e;

  // --------------------------------------------------
  // Address views
  // --------------------------------------------------
  // Region tag selects the window, word index selects the scratchpad row
  typedef struct packed {
    logic [TagWidth-1:0] region_tag;
    logic [IdxWidth-1:0] word_idx;
    logic [1:0]          byte_off;
  } lsu_addr_fields_t;

  typedef union packed {
    logic [AddrWidth-1:0] flat;
    lsu_addr_fields_t     fields;
  } lsu_addr_u;

endpackage

// ==== verilog/lsu_scratchpad.sv ====
// Word-wide data memory with byte write enables and a registered read.
// A write does not update the read port. Contents start undefined.

module lsu_scratchpad (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [lsu_pkg::IdxWidth-1:0]    idx_i,
  input  logic [lsu_pkg::BeWidth-1:0]     be_i,
  input  logic [lsu_pkg::DataWidth-1:0]   wdata_i,
  output logic [lsu_pkg::DataWidth-1:0]   rdata_o
);
  import lsu_pkg::*;

  logic [DataWidth-1:0] mem_q [2**IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        // Read data holds until the next read request
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

// ==== verilog/lsu_agu_stage.sv ====
// First stage: address generation and access checks.
// Accesses outside the BaseTag region fault; a fault overrides misalignment.
// Byte enables are formed even for faulting accesses but are never used then.

module lsu_agu_stage #(
  parameter logic [lsu_pkg::TagWidth-1:0] BaseTag = '0
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  lsu_pkg::lsu_op_e                   in_op_i,
  input  logic [lsu_pkg::DataWidth-1:0]      in_base_i,
  input  logic [lsu_pkg::DataWidth-1:0]      in_imm_i,
  input  logic [lsu_pkg::DataWidth-1:0]      in_wdata_i,
  input  logic [lsu_pkg::TransIdWidth-1:0]   in_trans_id_i,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output lsu_pkg::lsu_op_e                   out_op_o,
  output lsu_pkg::lsu_addr_u                 out_addr_o,
  output logic [lsu_pkg::BeWidth-1:0]        out_be_o,
  output logic [lsu_pkg::DataWidth-1:0]      out_wdata_o,
  output logic [lsu_pkg::TransIdWidth-1:0]   out_trans_id_o,
  output logic                               out_ex_valid_o,
  output lsu_pkg::ex_cause_e                 out_ex_cause_o
);
  import lsu_pkg::*;

  lsu_addr_u          addr;
  logic [BeWidth-1:0] be;
  logic               is_store;
  logic               misaligned;
  logic               fault;
  ex_cause_e          ex_cause;
  logic               accept;

  assign is_store = in_op_i inside {SB, SH, SW};

  // Address add, byte enables and alignment by access size
  always_comb begin
    addr.flat = AddrWidth'(in_base_i + in_imm_i);
    unique case (in_op_i)
      LB, LBU, SB: begin
        be         = BeWidth'(1) << addr.fields.byte_off;
        misaligned = 1'b0;
      end
      LH, LHU, SH: begin
        be         = BeWidth'(3) << addr.fields.byte_off;
        misaligned = addr.fields.byte_off[0];
      end
      default: begin
        be         = '1;
        misaligned = addr.fields.byte_off != 2'b00;
      end
    endcase
  end

  // Upper bits must hit the scratchpad region
  assign fault = addr.fields.region_tag != BaseTag;

  always_comb begin
    if (fault) begin
      ex_cause = is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else begin
      ex_cause = is_store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end
  end

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_op_o       <= in_op_i;
      out_addr_o     <= addr;
      out_be_o       <= be;
      out_wdata_o    <= in_wdata_i;
      out_trans_id_o <= in_trans_id_i;
      out_ex_valid_o <= fault || misaligned;
      out_ex_cause_o <= ex_cause;
    end
  end

endmodule

// ==== verilog/lsu_mem_stage.sv ====
// Second stage: scratchpad access.
// The memory is touched only on the edge that accepts an item, so read data
// stays stable while this stage is stalled. Accesses with an exception skip memory.

module lsu_mem_stage (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  lsu_pkg::lsu_op_e                   in_op_i,
  input  lsu_pkg::lsu_addr_u                 in_addr_i,
  input  logic [lsu_pkg::BeWidth-1:0]        in_be_i,
  input  logic [lsu_pkg::DataWidth-1:0]      in_wdata_i,
  input  logic [lsu_pkg::TransIdWidth-1:0]   in_trans_id_i,
  input  logic                               in_ex_valid_i,
  input  lsu_pkg::ex_cause_e                 in_ex_cause_i,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output lsu_pkg::lsu_op_e                   out_op_o,
  output logic [1:0]                         out_byte_off_o,
  output logic [lsu_pkg::DataWidth-1:0]      out_rdata_o,
  output logic [lsu_pkg::TransIdWidth-1:0]   out_trans_id_o,
  output logic                               out_ex_valid_o,
  output lsu_pkg::ex_cause_e                 out_ex_cause_o,
  output logic [lsu_pkg::AddrWidth-1:0]      out_ex_tval_o
);
  import lsu_pkg::*;

  logic                 accept;
  logic                 mem_req;
  logic                 mem_we;
  logic [DataWidth-1:0] wdata_lane;

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  // Move store data into the byte lanes selected by the offset
  assign wdata_lane = in_wdata_i << {in_addr_i.fields.byte_off, 3'b000};

  assign mem_req = accept && !in_ex_valid_i;
  assign mem_we  = in_op_i inside {SB, SH, SW};

  lsu_scratchpad scratchpad_i (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .idx_i   (in_addr_i.fields.word_idx),
    .be_i    (in_be_i),
    .wdata_i (wdata_lane),
    .rdata_o (out_rdata_o)
  );

  // Control fields travel next to the registered read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_op_o       <= in_op_i;
      out_byte_off_o <= in_addr_i.fields.byte_off;
      out_trans_id_o <= in_trans_id_i;
      out_ex_valid_o <= in_ex_valid_i;
      out_ex_cause_o <= in_ex_cause_i;
      out_ex_tval_o  <= in_addr_i.flat;
    end
  end

endmodule

// ==== verilog/lsu_result_stage.sv ====
// Third stage: load alignment and the result register.
// Stores and any access with an exception return zero data.
// All result outputs are registered and hold while the consumer stalls.

module lsu_result_stage (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  lsu_pkg::lsu_op_e                   in_op_i,
  input  logic [1:0]                         in_byte_off_i,
  input  logic [lsu_pkg::DataWidth-1:0]      in_rdata_i,
  input  logic [lsu_pkg::TransIdWidth-1:0]   in_trans_id_i,
  input  logic                               in_ex_valid_i,
  input  lsu_pkg::ex_cause_e                 in_ex_cause_i,
  input  logic [lsu_pkg::AddrWidth-1:0]      in_ex_tval_i,
  output logic                               res_valid_o,
  input  logic                               out_ready_i,
  output logic [lsu_pkg::TransIdWidth-1:0]   res_trans_id_o,
  output logic [lsu_pkg::DataWidth-1:0]      res_rdata_o,
  output logic                               res_ex_valid_o,
  output lsu_pkg::ex_cause_e                 res_ex_cause_o,
  output logic [lsu_pkg::AddrWidth-1:0]      res_ex_tval_o
);
  import lsu_pkg::*;

  logic [7:0]           byte_sel;
  logic [15:0]          half_sel;
  logic [DataWidth-1:0] data_ext;
  logic                 accept;

  // Pick the lane, then extend by operation
  always_comb begin
    byte_sel = in_rdata_i[{in_byte_off_i, 3'b000} +: 8];
    half_sel = in_rdata_i[{in_byte_off_i[1], 4'b0000} +: 16];
    unique case (in_op_i)
      LB:      data_ext = {{(DataWidth - 8){byte_sel[7]}}, byte_sel};
      LBU:     data_ext = {{(DataWidth - 8){1'b0}}, byte_sel};
      LH:      data_ext = {{(DataWidth - 16){half_sel[15]}}, half_sel};
      LHU:     data_ext = {{(DataWidth - 16){1'b0}}, half_sel};
      LW:      data_ext = in_rdata_i;
      default: data_ext = '0;
    endcase
    if (in_ex_valid_i) begin
      data_ext = '0;
    end
  end

  // --------------------------------------------------
  // Result register
  // --------------------------------------------------
  assign in_ready_o = !res_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      res_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_trans_id_o <= in_trans_id_i;
      res_rdata_o    <= data_ext;
      res_ex_valid_o <= in_ex_valid_i;
      res_ex_cause_o <= in_ex_cause_i;
      res_ex_tval_o  <= in_ex_tval_i;
    end
  end

endmodule

// ==== verilog/lsu_top.sv ====
// Load/store unit in front of a private data scratchpad.
// Three stages with valid/ready on every link; one request per cycle.
// BaseTag sets the upper address bits at which the scratchpad is mapped.

module lsu_top #(
  parameter logic [lsu_pkg::TagWidth-1:0] BaseTag = 20'h80000
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  lsu_pkg::lsu_op_e                   req_op_i,
  input  logic [lsu_pkg::DataWidth-1:0]      req_base_i,
  input  logic [lsu_pkg::DataWidth-1:0]      req_imm_i,
  input  logic [lsu_pkg::DataWidth-1:0]      req_wdata_i,
  input  logic [lsu_pkg::TransIdWidth-1:0]   req_trans_id_i,
  output logic                               res_valid_o,
  input  logic                               res_ready_i,
  output logic [lsu_pkg::TransIdWidth-1:0]   res_trans_id_o,
  output logic [lsu_pkg::DataWidth-1:0]      res_rdata_o,
  output logic                               res_ex_valid_o,
  output lsu_pkg::ex_cause_e                 res_ex_cause_o,
  output logic [lsu_pkg::AddrWidth-1:0]      res_ex_tval_o
);
  import lsu_pkg::*;

  // AGU to mem stage
  logic                    a_valid;
  logic                    a_ready;
  lsu_op_e                 a_op;
  lsu_addr_u               a_addr;
  logic [BeWidth-1:0]      a_be;
  logic [DataWidth-1:0]    a_wdata;
  logic [TransIdWidth-1:0] a_trans_id;
  logic                    a_ex_valid;
  ex_cause_e               a_ex_cause;

  // Mem stage to result stage
  logic                    m_valid;
  logic                    m_ready;
  lsu_op_e                 m_op;
  logic [1:0]              m_byte_off;
  logic [DataWidth-1:0]    m_rdata;
  logic [TransIdWidth-1:0] m_trans_id;
  logic                    m_ex_valid;
  ex_cause_e               m_ex_cause;
  logic [AddrWidth-1:0]    m_ex_tval;

  lsu_agu_stage #(
    .BaseTag (BaseTag)
  ) agu_stage_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (req_valid_i),
    .in_ready_o     (req_ready_o),
    .in_op_i        (req_op_i),
    .in_base_i      (req_base_i),
    .in_imm_i       (req_imm_i),
    .in_wdata_i     (req_wdata_i),
    .in_trans_id_i  (req_trans_id_i),
    .out_valid_o    (a_valid),
    .out_ready_i    (a_ready),
    .out_op_o       (a_op),
    .out_addr_o     (a_addr),
    .out_be_o       (a_be),
    .out_wdata_o    (a_wdata),
    .out_trans_id_o (a_trans_id),
    .out_ex_valid_o (a_ex_valid),
    .out_ex_cause_o (a_ex_cause)
  );

  lsu_mem_stage mem_stage_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (a_valid),
    .in_ready_o     (a_ready),
    .in_op_i        (a_op),
    .in_addr_i      (a_addr),
    .in_be_i        (a_be),
    .in_wdata_i     (a_wdata),
    .in_trans_id_i  (a_trans_id),
    .in_ex_valid_i  (a_ex_valid),
    .in_ex_cause_i  (a_ex_cause),
    .out_valid_o    (m_valid),
    .out_ready_i    (m_ready),
    .out_op_o       (m_op),
    .out_byte_off_o (m_byte_off),
    .out_rdata_o    (m_rdata),
    .out_trans_id_o (m_trans_id),
    .out_ex_valid_o (m_ex_valid),
    .out_ex_cause_o (m_ex_cause),
    .out_ex_tval_o  (m_ex_tval)
  );

  lsu_result_stage result_stage_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (m_valid),
    .in_ready_o     (m_ready),
    .in_op_i        (m_op),
    .in_byte_off_i  (m_byte_off),
    .in_rdata_i     (m_rdata),
    .in_trans_id_i  (m_trans_id),
    .in_ex_valid_i  (m_ex_valid),
    .in_ex_cause_i  (m_ex_cause),
    .in_ex_tval_i   (m_ex_tval),
    .res_valid_o    (res_valid_o),
    .out_ready_i    (res_ready_i),
    .res_trans_id_o (res_trans_id_o),
    .res_rdata_o    (res_rdata_o),
    .res_ex_valid_o (res_ex_valid_o),
    .res_ex_cause_o (res_ex_cause_o),
    .res_ex_tval_o  (res_ex_tval_o)
  );

endmodule

// ==== dv/lsu_tb_vectors.svh ====
// Stimulus and expected results for the LSU testbench, issued in table order.
// Addresses assume BaseTag 20'h00010, so the window is 0x00010000 to 0x00010fff.
// Cause and tval are only compared where an exception is expected.

`ifndef LSU_TB_VECTORS_SVH
`define LSU_TB_VECTORS_SVH

localparam int NumVectors = 27;

// Columns: op, base, imm, wdata, trans_id, exp_data, exp_ex, exp_cause, exp_tval
vector_t vectors [NumVectors] = '{
  // Word store then load, back to back
  '{SW,  32'h00010000, 32'h10, 32'hDEADBEEF, 3'd0, 32'h0, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LW,  32'h00010000, 32'h10, 32'h0, 3'd1, 32'hDEADBEEF, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  // Build 0x80017f80 from byte and halfword stores
  '{SH,  32'h00010000, 32'h22, 32'h00008001, 3'd2, 32'h0, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{SB,  32'h00010000, 32'h20, 32'h00000080, 3'd3, 32'h0, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{SB,  32'h00010000, 32'h21, 32'hFFFFFF7F, 3'd4, 32'h0, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LB,  32'h00010000, 32'h20, 32'h0, 3'd5, 32'hFFFFFF80, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LBU, 32'h00010000, 32'h20, 32'h0, 3'd6, 32'h00000080, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LB,  32'h00010000, 32'h21, 32'h0, 3'd7, 32'h0000007F, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LH,  32'h00010000, 32'h22, 32'h0, 3'd0, 32'hFFFF8001, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LHU, 32'h00010000, 32'h22, 32'h0, 3'd1, 32'h00008001, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LHU, 32'h00010000, 32'h20, 32'h0, 3'd2, 32'h00007F80, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LBU, 32'h00010000, 32'h23, 32'h0, 3'd3, 32'h00000080, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LW,  32'h00010000, 32'h20, 32'h0, 3'd4, 32'h80017F80, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  // Misaligned accesses, memory must stay unchanged
  '{LH,  32'h00010000, 32'h21, 32'h0, 3'd5, 32'h0, 1'b1, LD_ADDR_MISALIGNED, 32'h00010021},
  '{SW,  32'h00010000, 32'h12, 32'h12345678, 3'd6, 32'h0, 1'b1, ST_ADDR_MISALIGNED,
    32'h00010012},
  '{SH,  32'h00010000, 32'h23, 32'h0000AAAA, 3'd7, 32'h0, 1'b1, ST_ADDR_MISALIGNED,
    32'h00010023},
  '{LW,  32'h00010000, 32'h10, 32'h0, 3'd0, 32'hDEADBEEF, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LW,  32'h00010000, 32'h20, 32'h0, 3'd1, 32'h80017F80, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  // Region faults; the store would alias word 0x00010010
  '{LW,  32'h00020000, 32'h10, 32'h0, 3'd2, 32'h0, 1'b1, LD_ACCESS_FAULT, 32'h00020010},
  '{SW,  32'h00011000, 32'h10, 32'h55555555, 3'd3, 32'h0, 1'b1, ST_ACCESS_FAULT, 32'h00011010},
  '{LH,  32'h00020000, 32'h33, 32'h0, 3'd4, 32'h0, 1'b1, LD_ACCESS_FAULT, 32'h00020033},
  '{SW,  32'hFFFF0000, 32'h2, 32'h1, 3'd5, 32'h0, 1'b1, ST_ACCESS_FAULT, 32'hFFFF0002},
  // Address add wraps around into the window
  '{LW,  32'hFFFFFFFF, 32'h00010011, 32'h0, 3'd6, 32'hDEADBEEF, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{SW,  32'h00010040, 32'hFFFFFFF0, 32'h0BADF00D, 3'd7, 32'h0, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LW,  32'h00010030, 32'h0, 32'h0, 3'd0, 32'h0BADF00D, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LBU, 32'h00010030, 32'h2, 32'h0, 3'd1, 32'h000000AD, 1'b0, LD_ADDR_MISALIGNED, 32'h0},
  '{LH,  32'h00010030, 32'h0, 32'h0, 3'd2, 32'hFFFFF00D, 1'b0, LD_ADDR_MISALIGNED, 32'h0}
};

`endif

// ==== dv/lsu_tb.sv ====
// Testbench for the load/store unit, driven from the table in lsu_tb_vectors.svh.
// Results are expected in issue order, one per request.
// Table loads only touch words that earlier stores have written.
// Random back-pressure on res_ready_i comes from an 8-bit LFSR.

module lsu_tb;
  import lsu_pkg::*;

  localparam int ClkPeriod  = 100;
  localparam int DriveDelay = 10;
  localparam logic [TagWidth-1:0] BaseTag = 20'h00010;

  typedef struct packed {
    lsu_op_e                 op;
    logic [DataWidth-1:0]    base;
    logic [DataWidth-1:0]    imm;
    logic [DataWidth-1:0]    wdata;
    logic [TransIdWidth-1:0] trans_id;
    logic [DataWidth-1:0]    exp_data;
    logic                    exp_ex;
    ex_cause_e               exp_cause;
    logic [AddrWidth-1:0]    exp_tval;
  } vector_t;

  `include "lsu_tb_vectors.svh"

  localparam int TimeoutCycles = 20 * NumVectors + 50;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    req_valid_i;
  logic                    req_ready_o;
  lsu_op_e                 req_op_i;
  logic [DataWidth-1:0]    req_base_i;
  logic [DataWidth-1:0]    req_imm_i;
  logic [DataWidth-1:0]    req_wdata_i;
  logic [TransIdWidth-1:0] req_trans_id_i;
  logic                    res_valid_o;
  logic                    res_ready_i;
  logic [TransIdWidth-1:0] res_trans_id_o;
  logic [DataWidth-1:0]    res_rdata_o;
  logic                    res_ex_valid_o;
  ex_cause_e               res_ex_cause_o;
  logic [AddrWidth-1:0]    res_ex_tval_o;

  logic [7:0] lfsr_q;
  int         error_count  = 0;
  int         failed_tests = 0;
  int         cycle_count  = 0;

  lsu_top #(
    .BaseTag (BaseTag)
  ) lsu_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_base_i     (req_base_i),
    .req_imm_i      (req_imm_i),
    .req_wdata_i    (req_wdata_i),
    .req_trans_id_i (req_trans_id_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_trans_id_o (res_trans_id_o),
    .res_rdata_o    (res_rdata_o),
    .res_ex_valid_o (res_ex_valid_o),
    .res_ex_cause_o (res_ex_cause_o),
    .res_ex_tval_o  (res_ex_tval_o)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_data(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: res_rdata_o got %h expected %h", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_trans_id(input logic [TransIdWidth-1:0] got,
                                input logic [TransIdWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: res_trans_id_o got %0d expected %0d", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_cause(input ex_cause_e got, input ex_cause_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: res_ex_cause_o got %0d expected %0d", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic check_tval(input logic [AddrWidth-1:0] got, input logic [AddrWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: res_ex_tval_o got %h expected %h", $time, got, exp);
      error_count++;
    end
  endtask

  // Fibonacci LFSR, taps 8 6 5 4, one step per bit taken
  function automatic logic random_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    return b;
  endfunction

  // --------------------------------------------------
  // Request and result processes
  // --------------------------------------------------
  task automatic drive_requests();
    for (int i = 0; i < NumVectors; i++) begin
      req_valid_i    = 1'b1;
      req_op_i       = vectors[i].op;
      req_base_i     = vectors[i].base;
      req_imm_i      = vectors[i].imm;
      req_wdata_i    = vectors[i].wdata;
      req_trans_id_i = vectors[i].trans_id;
      // Inputs are stable until the next edge, so the negedge shows the handshake
      @(negedge clk_i);
      while (!req_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #DriveDelay;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic collect_results();
    int errors_before;
    for (int i = 0; i < NumVectors; i++) begin
      @(negedge clk_i);
      while (!(res_valid_o && res_ready_i)) begin
        @(negedge clk_i);
      end
      errors_before = error_count;
      check_trans_id(res_trans_id_o, vectors[i].trans_id);
      check_data(res_rdata_o, vectors[i].exp_data);
      check_flag("res_ex_valid_o", res_ex_valid_o, vectors[i].exp_ex);
      if (vectors[i].exp_ex) begin
        check_cause(res_ex_cause_o, vectors[i].exp_cause);
        check_tval(res_ex_tval_o, vectors[i].exp_tval);
      end
      if (error_count == errors_before) begin
        $display("Test %0d %s id %0d ok", i, vectors[i].op.name(), vectors[i].trans_id);
      end else begin
        $display("Test %0d %s id %0d FAILED", i, vectors[i].op.name(), vectors[i].trans_id);
        failed_tests++;
      end
      @(posedge clk_i);
    end
    // No extra result may follow the last one
    repeat (4) @(negedge clk_i);
    check_flag("res_valid_o", res_valid_o, 1'b0);
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    logic bit_a;
    logic bit_b;
    lfsr_q      = 8'd78;
    res_ready_i = 1'b1;
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      bit_a       = random_bit();
      bit_b       = random_bit();
      res_ready_i = bit_a | bit_b;
    end
  end

  initial begin
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = LB;
    req_base_i     = '0;
    req_imm_i      = '0;
    req_wdata_i    = '0;
    req_trans_id_i = '0;
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    // Pipeline empty after reset
    @(negedge clk_i);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    @(posedge clk_i);
    #DriveDelay;
    fork
      drive_requests();
      collect_results();
    join
    $display("Summary: %0d tests, %0d failed, %0d errors", NumVectors, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, results are still missing", cycle_count);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+dv
verilog/lsu_pkg.sv
verilog/lsu_scratchpad.sv
verilog/lsu_agu_stage.sv
verilog/lsu_mem_stage.sv
verilog/lsu_result_stage.sv
verilog/lsu_top.sv
dv/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench result
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module lsu_tb -f compile.f -o lsu_sim &&
  ./obj_dir/lsu_sim | tee /dev/stderr | grep -qx "all tests passed" &&
  echo "Simulation passed" ||
  { echo "Simulation did not pass"; exit 1; }
